// ==== include/counter_regs_config.svh ====
`ifndef COUNTER_REGS_CONFIG_SVH
`define COUNTER_REGS_CONFIG_SVH

// AXI4-Lite bus geometry
`define AXIL_ADDR_WIDTH 16 // Byte address width
`define AXIL_DATA_WIDTH 32 // Data word width

// Counter bank size, up to 32
`define NUM_COUNTERS 4

// Address bit that selects the status half when set
`define REGION_BIT 12

`endif

// ==== source/axil_pkg.sv ====
`include "counter_regs_config.svh"

package axil_pkg;

  // Response codes used on bresp and rresp
  typedef enum logic [1:0]
  {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axil_resp_e;

  // Signals driven by the bus master
  typedef struct packed
  {
    logic [`AXIL_ADDR_WIDTH-1:0] awaddr;  // Write address
    logic                        awvalid; // Write address valid
    logic [`AXIL_DATA_WIDTH-1:0] wdata;   // Write data
    logic                        wvalid;  // Write data valid
    logic                        bready;  // Write response ready
    logic [`AXIL_ADDR_WIDTH-1:0] araddr;  // Read address
    logic                        arvalid; // Read address valid
    logic                        rready;  // Read data ready
  } axil_req_t;

  // Signals driven by a slave
  typedef struct packed
  {
    logic                        awready; // Write address ready
    logic                        wready;  // Write data ready
    axil_resp_e                  bresp;   // Write response
    logic                        bvalid;  // Write response valid
    logic                        arready; // Read address ready
    logic [`AXIL_DATA_WIDTH-1:0] rdata;   // Read data
    axil_resp_e                  rresp;   // Read response
    logic                        rvalid;  // Read data valid
  } axil_rsp_t;

endpackage

// ==== source/counter_regs_pkg.sv ====
`include "counter_regs_config.svh"

package counter_regs_pkg;

  // Which half of the address map a transaction targets
  typedef enum logic
  {
    ROUTE_CFG = 1'b0, // Configuration register, read/write
    ROUTE_STS = 1'b1  // Status register, read only
  } route_e;

  // Configuration words, word 0 in the low bits
  // Only the low NUM_COUNTERS bits of each mask act
  typedef struct packed
  {
    logic [`AXIL_DATA_WIDTH-1:0] clear_mask;  // Word 1
    logic [`AXIL_DATA_WIDTH-1:0] enable_mask; // Word 0
  } cfg_t;

  // Status words, word i holds counter i
  typedef struct packed
  {
    logic [`NUM_COUNTERS-1:0][`AXIL_DATA_WIDTH-1:0] count;
  } sts_t;

endpackage

// ==== source/axil_region_splitter.sv ====
`timescale 1ns/1ps

`include "counter_regs_config.svh"

module axil_region_splitter
(
  input  logic                aclk,
  input  logic                aresetn,
  input  axil_pkg::axil_req_t s_req,
  output axil_pkg::axil_rsp_t s_rsp,
  output axil_pkg::axil_req_t cfg_req,
  input  axil_pkg::axil_rsp_t cfg_rsp,
  output axil_pkg::axil_req_t sts_req,
  input  axil_pkg::axil_rsp_t sts_rsp
);

  counter_regs_pkg::route_e aw_route; // Decoded from awaddr
  counter_regs_pkg::route_e ar_route; // Decoded from araddr
  counter_regs_pkg::route_e wr_route_q; // Route of the outstanding write
  counter_regs_pkg::route_e rd_route_q; // Route of the outstanding read
  logic                     wr_busy_q;
  logic                     rd_busy_q;
  logic                     err_accept; // Status write taken by the splitter
  logic                     wr_accept;
  logic                     rd_accept;

  assign aw_route = counter_regs_pkg::route_e'(s_req.awaddr[`REGION_BIT]);
  assign ar_route = counter_regs_pkg::route_e'(s_req.araddr[`REGION_BIT]);

  assign err_accept = s_req.awvalid & s_req.wvalid & ~wr_busy_q &
                      (aw_route == counter_regs_pkg::ROUTE_STS);

  always_comb
  begin
    cfg_req         = s_req;
    cfg_req.awvalid = s_req.awvalid & ~wr_busy_q & (aw_route == counter_regs_pkg::ROUTE_CFG);
    cfg_req.wvalid  = s_req.wvalid & ~wr_busy_q & (aw_route == counter_regs_pkg::ROUTE_CFG);
    cfg_req.bready  = s_req.bready & (wr_route_q == counter_regs_pkg::ROUTE_CFG);
    cfg_req.arvalid = s_req.arvalid & ~rd_busy_q & (ar_route == counter_regs_pkg::ROUTE_CFG);
    cfg_req.rready  = s_req.rready & (rd_route_q == counter_regs_pkg::ROUTE_CFG);

    sts_req         = s_req;
    sts_req.awvalid = 1'b0; // Status writes never reach the slave
    sts_req.wvalid  = 1'b0;
    sts_req.bready  = 1'b0;
    sts_req.arvalid = s_req.arvalid & ~rd_busy_q & (ar_route == counter_regs_pkg::ROUTE_STS);
    sts_req.rready  = s_req.rready & (rd_route_q == counter_regs_pkg::ROUTE_STS);
  end

  always_comb
  begin
    s_rsp = '0;

    // Address and data ready follow the currently decoded route
    if (aw_route == counter_regs_pkg::ROUTE_STS)
    begin
      s_rsp.awready = err_accept;
      s_rsp.wready  = err_accept;
    end
    else
    begin
      s_rsp.awready = cfg_rsp.awready;
      s_rsp.wready  = cfg_rsp.wready;
    end
    s_rsp.arready = (ar_route == counter_regs_pkg::ROUTE_STS) ? sts_rsp.arready
                                                              : cfg_rsp.arready;

    // Responses follow the stored route
    if (wr_route_q == counter_regs_pkg::ROUTE_STS)
    begin
      s_rsp.bvalid = wr_busy_q;
      s_rsp.bresp  = axil_pkg::RESP_SLVERR;
    end
    else
    begin
      s_rsp.bvalid = cfg_rsp.bvalid;
      s_rsp.bresp  = cfg_rsp.bresp;
    end
    s_rsp.rvalid = (rd_route_q == counter_regs_pkg::ROUTE_STS) ? sts_rsp.rvalid : cfg_rsp.rvalid;
    s_rsp.rdata  = (rd_route_q == counter_regs_pkg::ROUTE_STS) ? sts_rsp.rdata  : cfg_rsp.rdata;
    s_rsp.rresp  = (rd_route_q == counter_regs_pkg::ROUTE_STS) ? sts_rsp.rresp  : cfg_rsp.rresp;
  end

  assign wr_accept = s_req.awvalid & s_rsp.awready;
  assign rd_accept = s_req.arvalid & s_rsp.arready;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_busy_q  <= 1'b0;
      rd_busy_q  <= 1'b0;
      wr_route_q <= counter_regs_pkg::ROUTE_CFG;
      rd_route_q <= counter_regs_pkg::ROUTE_CFG;
    end
    else
    begin
      if (wr_accept)
      begin
        wr_busy_q  <= 1'b1;
        wr_route_q <= aw_route;
      end
      else if (s_rsp.bvalid && s_req.bready)
      begin
        wr_busy_q <= 1'b0; // Response delivered
      end

      if (rd_accept)
      begin
        rd_busy_q  <= 1'b1;
        rd_route_q <= ar_route;
      end
      else if (s_rsp.rvalid && s_req.rready)
      begin
        rd_busy_q <= 1'b0;
      end
    end
  end

endmodule

// ==== source/axi_cfg_register.sv ====
`timescale 1ns/1ps

`include "counter_regs_config.svh"

module axi_cfg_register
(
  input  logic                    aclk,
  input  logic                    aresetn,
  input  axil_pkg::axil_req_t     s_req,
  output axil_pkg::axil_rsp_t     s_rsp,
  output counter_regs_pkg::cfg_t  cfg
);

  localparam int CFG_WORDS = $bits(counter_regs_pkg::cfg_t) / `AXIL_DATA_WIDTH;
  localparam int ADDR_LSB  = $clog2(`AXIL_DATA_WIDTH / 8); // Byte offset bits
  localparam int IDX_W     = (CFG_WORDS > 1) ? $clog2(CFG_WORDS) : 1;

  logic [`AXIL_DATA_WIDTH-1:0] words [CFG_WORDS];
  logic [IDX_W-1:0]            aw_idx;
  logic [IDX_W-1:0]            ar_idx;
  logic                        bvalid_q;
  logic                        rvalid_q;
  logic [`AXIL_DATA_WIDTH-1:0] rdata_q;
  logic                        wr_accept;
  logic                        rd_accept;

  // Word index sits just above the byte offset and wraps over the words
  assign aw_idx = s_req.awaddr[ADDR_LSB +: IDX_W];
  assign ar_idx = s_req.araddr[ADDR_LSB +: IDX_W];

  assign wr_accept = s_req.awvalid & s_req.wvalid & ~bvalid_q;
  assign rd_accept = s_req.arvalid & ~rvalid_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      for (int i = 0; i < CFG_WORDS; i++)
      begin
        words[i] <= '0;
      end
      bvalid_q <= 1'b0;
    end
    else
    begin
      if (wr_accept)
      begin
        words[aw_idx] <= s_req.wdata;
        bvalid_q      <= 1'b1;
      end
      else if (bvalid_q && s_req.bready)
      begin
        bvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rvalid_q <= 1'b0;
    end
    else if (rd_accept)
    begin
      rvalid_q <= 1'b1;
    end
    else if (rvalid_q && s_req.rready)
    begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rd_accept)
    begin
      rdata_q <= words[ar_idx]; // Held until the read completes
    end
  end

  always_comb
  begin
    s_rsp         = '0;
    s_rsp.awready = wr_accept; // Address and data taken together
    s_rsp.wready  = wr_accept;
    s_rsp.bresp   = axil_pkg::RESP_OKAY;
    s_rsp.bvalid  = bvalid_q;
    s_rsp.arready = rd_accept;
    s_rsp.rdata   = rdata_q;
    s_rsp.rresp   = axil_pkg::RESP_OKAY;
    s_rsp.rvalid  = rvalid_q;
  end

  assign cfg.enable_mask = words[0];
  assign cfg.clear_mask  = words[1];

endmodule

// ==== source/axi_sts_register.sv ====
`timescale 1ns/1ps

`include "counter_regs_config.svh"

module axi_sts_register
(
  input  logic                    aclk,
  input  logic                    aresetn,
  input  counter_regs_pkg::sts_t  sts,
  input  axil_pkg::axil_req_t     s_req,
  output axil_pkg::axil_rsp_t     s_rsp
);

  localparam int ADDR_LSB = $clog2(`AXIL_DATA_WIDTH / 8);
  localparam int IDX_W    = (`NUM_COUNTERS > 1) ? $clog2(`NUM_COUNTERS) : 1;

  logic [IDX_W-1:0]            ar_idx;
  logic [IDX_W-1:0]            sel;
  logic                        rvalid_q;
  logic [`AXIL_DATA_WIDTH-1:0] rdata_q;
  logic                        rd_accept;

  assign ar_idx = s_req.araddr[ADDR_LSB +: IDX_W];
  assign sel    = IDX_W'(ar_idx % `NUM_COUNTERS); // Wrap for non power of two counts

  assign rd_accept = s_req.arvalid & ~rvalid_q;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rvalid_q <= 1'b0;
    end
    else if (rd_accept)
    begin
      rvalid_q <= 1'b1;
    end
    else if (rvalid_q && s_req.rready)
    begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge aclk)
  begin
    if (rd_accept)
    begin
      rdata_q <= sts.count[sel]; // Snapshot at the accepting edge
    end
  end

  always_comb
  begin
    s_rsp         = '0; // Write channels stay idle
    s_rsp.bresp   = axil_pkg::RESP_OKAY;
    s_rsp.arready = rd_accept;
    s_rsp.rdata   = rdata_q;
    s_rsp.rresp   = axil_pkg::RESP_OKAY;
    s_rsp.rvalid  = rvalid_q;
  end

endmodule

// ==== source/event_counter_bank.sv ====
`timescale 1ns/1ps

`include "counter_regs_config.svh"

module event_counter_bank
(
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic [`NUM_COUNTERS-1:0] events,
  input  counter_regs_pkg::cfg_t   cfg,
  output counter_regs_pkg::sts_t   sts
);

  logic [`NUM_COUNTERS-1:0] enable; // Active part of each mask
  logic [`NUM_COUNTERS-1:0] clear;
  logic [`NUM_COUNTERS-1:0] bump;

  assign enable = cfg.enable_mask[`NUM_COUNTERS-1:0];
  assign clear  = cfg.clear_mask[`NUM_COUNTERS-1:0];
  assign bump   = events & enable;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      sts <= '0;
    end
    else
    begin
      for (int i = 0; i < `NUM_COUNTERS; i++)
      begin
        if (clear[i])
        begin
          sts.count[i] <= '0; // Held at zero while clear is set
        end
        else if (bump[i])
        begin
          sts.count[i] <= sts.count[i] + 1'b1; // Wraps at 2^32
        end
      end
    end
  end

endmodule

// ==== source/counter_regs_top.sv ====
`timescale 1ns/1ps

`include "counter_regs_config.svh"

module counter_regs_top
(
  input  logic                     aclk,
  input  logic                     aresetn,
  input  axil_pkg::axil_req_t      s_req,
  output axil_pkg::axil_rsp_t      s_rsp,
  input  logic [`NUM_COUNTERS-1:0] events
);

  axil_pkg::axil_req_t    cfg_req;
  axil_pkg::axil_rsp_t    cfg_rsp;
  axil_pkg::axil_req_t    sts_req;
  axil_pkg::axil_rsp_t    sts_rsp;
  counter_regs_pkg::cfg_t cfg;
  counter_regs_pkg::sts_t sts;

  axil_region_splitter u_splitter
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_req   (s_req),
    .s_rsp   (s_rsp),
    .cfg_req (cfg_req),
    .cfg_rsp (cfg_rsp),
    .sts_req (sts_req),
    .sts_rsp (sts_rsp)
  );

  axi_cfg_register u_cfg
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_req   (cfg_req),
    .s_rsp   (cfg_rsp),
    .cfg     (cfg)
  );

  axi_sts_register u_sts
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .sts     (sts),
    .s_req   (sts_req),
    .s_rsp   (sts_rsp)
  );

  event_counter_bank u_counters
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .events  (events),
    .cfg     (cfg),
    .sts     (sts)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
  output logic aclk,
  output logic aresetn
);

  initial
  begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk; // 20 ns period
  end

  initial
  begin
    aresetn <= 1'b0;
    repeat (5) @(posedge aclk);
    aresetn <= 1'b1; // Released on a rising edge
  end

endmodule

// ==== test/tb_counter_regs.sv ====
`timescale 1ns/1ps

`include "counter_regs_config.svh"

module tb_counter_regs;

  typedef logic [`AXIL_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0] data_t;

  localparam int    N          = `NUM_COUNTERS;
  localparam int    STS_IDX_W  = (N > 1) ? $clog2(N) : 1;
  localparam addr_t STS_BASE   = addr_t'(1) << `REGION_BIT;
  localparam addr_t CFG_ENABLE = addr_t'(0);
  localparam addr_t CFG_CLEAR  = addr_t'(4);

  logic                aclk;
  logic                aresetn;
  axil_pkg::axil_req_t req;
  axil_pkg::axil_rsp_t rsp;
  logic [N-1:0]        events;

  integer seed      = 32'hbee9;
  logic   ev_on     = 1'b0; // Random event pulses running
  logic   ev_hold   = 1'b0; // Events frozen while a read is in progress
  logic   b_open    = 1'b0; // Write response shown and not yet taken
  logic   r_open    = 1'b0; // Read response shown and not yet taken
  int     errors    = 0;
  int     checks    = 0;
  int     tests     = 0;
  int     wr_issued = 0;
  int     rd_issued = 0;
  int     aw_count  = 0;
  int     b_count   = 0;
  int     ar_count  = 0;
  int     r_count   = 0;

  data_t m_cfg [2]; // Model of the configuration words
  data_t m_cnt [N]; // Model of the counters

  tb_clock_gen u_clk
  (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  counter_regs_top u_dut
  (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_req   (req),
    .s_rsp   (rsp),
    .events  (events)
  );

  // Counters see the events driven in the previous cycle
  always @(posedge aclk)
  begin
    for (int i = 0; i < N; i++)
    begin
      if (!aresetn || m_cfg[1][i])
        m_cnt[i] <= '0;
      else if (events[i] && m_cfg[0][i])
        m_cnt[i] <= m_cnt[i] + 1; // Wraps at 2^32
    end
  end

  // Ready pulses and freshly presented responses, whatever the master does
  always @(posedge aclk)
  begin
    if (aresetn)
    begin
      if (rsp.awready)
        aw_count++;
      if (rsp.bvalid && !b_open)
        b_count++;
      b_open <= rsp.bvalid && !req.bready;
      if (rsp.arready)
        ar_count++;
      if (rsp.rvalid && !r_open)
        r_count++;
      r_open <= rsp.rvalid && !req.rready;
    end
  end

  function automatic int rand_below(input int n);
    return int'(($random(seed) & 32'h7fff_ffff) % n);
  endfunction

  function automatic data_t model_read(input addr_t addr);
    int idx;
    if (counter_regs_pkg::route_e'(addr[`REGION_BIT]) == counter_regs_pkg::ROUTE_STS)
    begin
      idx = int'(addr[2 +: STS_IDX_W]) % N; // Index bits wrap over the counters
      return m_cnt[idx];
    end
    return m_cfg[addr[2]];
  endfunction

  task automatic check(input data_t actual, input data_t expected, input string what);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    $display("Timeout at %0d ns: no %s within 100 cycles", $time, what);
  endtask

  task automatic report_test(input string name, input int base);
    tests++;
    $display("[%0d] %s: %0d mismatches", tests, name, errors - base);
  endtask

  // One clock edge, with fresh event pulses when enabled
  task automatic tick();
    @(posedge aclk);
    if (!ev_on)
      events <= '0;
    else if (!ev_hold)
      events <= N'($random(seed));
  endtask

  task automatic bus_write(input addr_t addr, input data_t data);
    axil_pkg::axil_resp_e exp_resp;
    axil_pkg::axil_resp_e first_resp;
    logic                 seen;
    logic                 done;
    int                   t;
    if (counter_regs_pkg::route_e'(addr[`REGION_BIT]) == counter_regs_pkg::ROUTE_STS)
      exp_resp = axil_pkg::RESP_SLVERR; // Status half takes no writes
    else
      exp_resp = axil_pkg::RESP_OKAY;
    first_resp = axil_pkg::RESP_OKAY;
    tick();
    req.awaddr  <= addr;
    req.wdata   <= data;
    req.awvalid <= 1'b1;
    req.wvalid  <= 1'b1;
    done = 1'b0;
    t    = 0;
    while (!done && t < 100)
    begin
      tick();
      t++;
      done = rsp.awready && rsp.wready;
    end
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    if (!done)
    begin
      note_timeout("write address and data handshake");
      return;
    end
    wr_issued++;
    if (exp_resp == axil_pkg::RESP_OKAY)
      m_cfg[addr[2]] <= data; // Visible to the counters from the next edge
    seen = 1'b0;
    done = 1'b0;
    t    = 0;
    while (!done && t < 100)
    begin
      tick();
      t++;
      if (seen)
      begin
        check(data_t'(rsp.bvalid), 1, "bvalid held under back-pressure");
        check(data_t'(rsp.bresp), data_t'(first_resp), "bresp held under back-pressure");
      end
      else if (rsp.bvalid)
      begin
        seen       = 1'b1;
        first_resp = rsp.bresp;
      end
      done = rsp.bvalid && req.bready;
      if (!done)
        req.bready <= (rand_below(4) != 0);
    end
    req.bready <= 1'b0;
    if (!done)
      note_timeout("write response");
    else
      check(data_t'(rsp.bresp), data_t'(exp_resp), "write response");
  endtask

  task automatic bus_read(input addr_t addr, output data_t data);
    data_t exp_data;
    data_t first_data;
    logic  seen;
    logic  done;
    int    t;
    data       = '0;
    first_data = '0;
    ev_hold    = 1'b1;
    tick();
    req.araddr  <= addr;
    req.arvalid <= 1'b1;
    done = 1'b0;
    t    = 0;
    while (!done && t < 100)
    begin
      tick();
      t++;
      done = rsp.arready;
    end
    req.arvalid <= 1'b0;
    exp_data = model_read(addr); // Model state before the accepting edge
    if (!done)
    begin
      note_timeout("read address handshake");
      ev_hold = 1'b0;
      return;
    end
    rd_issued++;
    seen = 1'b0;
    done = 1'b0;
    t    = 0;
    while (!done && t < 100)
    begin
      tick();
      t++;
      if (seen)
      begin
        check(data_t'(rsp.rvalid), 1, "rvalid held under back-pressure");
        check(rsp.rdata, first_data, "rdata held under back-pressure");
      end
      else if (rsp.rvalid)
      begin
        seen       = 1'b1;
        first_data = rsp.rdata;
      end
      done = rsp.rvalid && req.rready;
      if (!done)
        req.rready <= (rand_below(4) != 0);
    end
    req.rready <= 1'b0;
    ev_hold = 1'b0;
    data    = rsp.rdata;
    if (!done)
    begin
      note_timeout("read response");
    end
    else
    begin
      check(rsp.rdata, exp_data, "read data");
      check(data_t'(rsp.rresp), data_t'(axil_pkg::RESP_OKAY), "read response");
    end
  endtask

  initial
  begin
    int    t;
    int    base;
    int    k;
    addr_t addr;
    data_t data;
    data_t rd;
    req      <= '0;
    events   <= '0;
    m_cfg[0] <= '0;
    m_cfg[1] <= '0;
    t = 0;
    while (aresetn !== 1'b1 && t < 100)
    begin
      @(posedge aclk);
      t++;
    end
    if (aresetn !== 1'b1)
      note_timeout("reset release");

    base = errors;
    for (int i = 0; i < 2; i++)
    begin
      bus_read(addr_t'(4 * i), rd);
      check(rd, '0, "config word after reset");
    end
    for (int i = 0; i < N; i++)
    begin
      bus_read(STS_BASE | addr_t'(4 * i), rd);
      check(rd, '0, "counter after reset");
    end
    report_test("reset values", base);

    base = errors;
    repeat (16)
    begin
      addr = addr_t'($random(seed)) & ~(STS_BASE | addr_t'(3)); // Upper bits wrap
      data = $random(seed);
      bus_write(addr, data);
      bus_read(addr, rd);
      check(rd, data, "config readback");
    end
    report_test("config write and readback", base);

    base = errors;
    repeat (8)
    begin
      addr = (addr_t'($random(seed)) & ~addr_t'(3)) | STS_BASE;
      bus_write(addr, $random(seed));
    end
    for (int i = 0; i < 2; i++)
      bus_read(addr_t'(4 * i), rd);
    for (int i = 0; i < N; i++)
      bus_read(STS_BASE | addr_t'(4 * i), rd);
    report_test("status writes rejected", base);

    base = errors;
    bus_write(CFG_CLEAR, '0);
    bus_write(CFG_ENABLE, $random(seed));
    ev_on = 1'b1;
    repeat (40)
    begin
      repeat (rand_below(8)) tick();
      if (rand_below(8) == 0)
        bus_write(CFG_ENABLE, $random(seed));
      bus_read(STS_BASE | addr_t'(4 * rand_below(N)), rd);
    end
    report_test("event counting", base);

    base = errors;
    k = rand_below(N);
    bus_write(CFG_ENABLE, '1);
    bus_write(CFG_CLEAR, data_t'(1) << k);
    repeat (8)
    begin
      repeat (rand_below(4)) tick();
      bus_read(STS_BASE | addr_t'(4 * k), rd);
      check(rd, '0, "counter held by clear");
    end
    bus_write(CFG_CLEAR, '0);
    repeat (8)
    begin
      repeat (rand_below(4)) tick();
      bus_read(STS_BASE | addr_t'(4 * k), rd); // Counts again from zero
    end
    report_test("clear mask", base);

    base = errors;
    repeat (30)
    begin
      addr = addr_t'($random(seed)) & ~addr_t'(3);
      if (rand_below(2) == 0)
        bus_write(addr, $random(seed));
      else
        bus_read(addr, rd);
    end
    ev_on = 1'b0;
    repeat (4) tick();
    check(data_t'(aw_count), data_t'(wr_issued), "write requests accepted");
    check(data_t'(b_count), data_t'(wr_issued), "write responses");
    check(data_t'(ar_count), data_t'(rd_issued), "read requests accepted");
    check(data_t'(r_count), data_t'(rd_issued), "read responses");
    report_test("mixed traffic with back-pressure", base);

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== counter_regs_top.f ====
+incdir+include
source/axil_pkg.sv
source/counter_regs_pkg.sv
source/axil_region_splitter.sv
source/axi_cfg_register.sv
source/axi_sts_register.sv
source/event_counter_bank.sv
source/counter_regs_top.sv
test/tb_clock_gen.sv
test/tb_counter_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the counter register testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module tb_counter_regs \
  -f counter_regs_top.f \
  -o tb_counter_regs

./obj_dir/tb_counter_regs | tee sim.log

if grep -q "Test failed" sim.log
then
  exit 1
fi
